/* rob_top.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_alloc_if.sv
rtl/dispatch_unit.sv
rtl/reorder_buffer.sv
rtl/commit_unit.sv
rtl/rob_top.sv
testbench/rob_top_tb.sv

/* rtl/commit_unit.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

module commit_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                head_valid,
    input  rob_pkg::rob_entry_t head_entry,
    output logic                pop,
    input  logic                commit_ready,
    output logic                commit_valid,
    output logic [4:0]          commit_rd,
    output logic [`XLEN-1:0]    commit_value
);

    logic slot_free; // Register empty or draining this cycle

    assign slot_free = !commit_valid || commit_ready;
    assign pop       = head_valid && slot_free;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            commit_valid <= 1'b0;
        end else if (slot_free) begin
            commit_valid <= head_valid;
        end
    end

    // Payload loads together with the head pop
    always_ff @(posedge clk) begin
        if (pop) begin
            commit_rd    <= head_entry.has_rd ? head_entry.rd : 5'd0;
            commit_value <= head_entry.value;
        end
    end

    // Held outputs under back-pressure
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst || flush)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_rd) && $stable(commit_value))
    ) else $error("commit outputs moved while stalled, rd %0h value %0h",
                  commit_rd, commit_value);

endmodule

/* rtl/dispatch_unit.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

module dispatch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instr_valid,
    input  rob_pkg::instr_u       instr,
    output logic                  instr_ready,
    output logic [`ROB_TAG_W-1:0] instr_tag,
    rob_alloc_if.dispatch         alloc
);

    logic                  s_view;   // Instruction has no destination
    logic                  has_rd;
    logic [4:0]            rd;
    logic [`ROB_TAG_W-1:0] disp_cnt; // Accepted instructions since reset or flush
    logic                  accept;

    // STORE and BRANCH share the S layout, where the rd slot holds immediate bits
    always_comb begin
        case (instr.s_fmt.opcode)
            rob_pkg::STORE,
            rob_pkg::BRANCH: s_view = 1'b1;
            default:         s_view = 1'b0;
        endcase
    end

    always_comb begin
        case (instr.r_fmt.opcode)
            rob_pkg::OP,
            rob_pkg::OP_IMM,
            rob_pkg::LOAD,
            rob_pkg::LUI,
            rob_pkg::JAL: has_rd = !s_view;
            default:      has_rd = 1'b0;
        endcase
    end

    assign rd = has_rd ? instr.r_fmt.rd : 5'd0;

    assign alloc.valid        = instr_valid;
    assign alloc.entry.has_rd = has_rd;
    assign alloc.entry.rd     = rd;
    assign alloc.entry.done   = !has_rd;   // Nothing to wait for
    assign alloc.entry.value  = '0;

    assign instr_ready = alloc.ready;
    assign instr_tag   = alloc.tag;
    assign accept      = instr_valid && alloc.ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            disp_cnt <= '0;
        end else if (accept) begin
            disp_cnt <= disp_cnt + 1'b1;
        end
    end

    // Tags follow dispatch order, so a tag returns only after its slot has drained
    a_tag_in_order: assert property (
        @(posedge clk) disable iff (rst || flush)
        accept |-> (alloc.tag == disp_cnt)
    ) else $error("tag %0h handed out, expected %0h", alloc.tag, disp_cnt);

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    rob_alloc_if.rob              alloc,
    input  logic                  wb_valid,
    input  logic [`ROB_TAG_W-1:0] wb_tag,
    input  logic [`XLEN-1:0]      wb_result,
    output logic                  head_valid,
    output rob_pkg::rob_entry_t   head_entry,
    input  logic                  pop
);

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];

    // Pointers carry one wrap bit above the index
    logic [`ROB_TAG_W:0]   head_ptr;
    logic [`ROB_TAG_W:0]   tail_ptr;
    logic [`ROB_TAG_W:0]   count;
    logic [`ROB_TAG_W-1:0] head_idx;
    logic [`ROB_TAG_W-1:0] tail_idx;
    logic [`ROB_TAG_W-1:0] wb_offset;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  wb_live;

    assign head_idx = head_ptr[`ROB_TAG_W-1:0];
    assign tail_idx = tail_ptr[`ROB_TAG_W-1:0];
    assign count    = tail_ptr - head_ptr;

    assign empty = (head_ptr == tail_ptr);
    assign full  = (head_idx == tail_idx) &&
                   (head_ptr[`ROB_TAG_W] != tail_ptr[`ROB_TAG_W]);

    assign alloc.ready = !full;
    assign alloc.tag   = tail_idx;
    assign push        = alloc.valid && alloc.ready;

    assign head_entry = entries[head_idx];
    assign head_valid = !empty && head_entry.done;

    // Tag is live when its distance from head is below occupancy
    assign wb_offset = wb_tag - head_idx;
    assign wb_live   = ({1'b0, wb_offset} < count);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // Flush cancels both writers of the entry array
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (wb_valid) begin
                entries[wb_tag].value <= wb_result;
                entries[wb_tag].done  <= 1'b1;
            end
            if (push) begin
                entries[tail_idx] <= alloc.entry;
            end
        end
    end

    // Commit may only take a finished head
    a_pop_done: assert property (
        @(posedge clk) disable iff (rst || flush)
        pop |-> head_valid
    ) else $error("pop with head %0h not ready", head_idx);

    // Occupancy overflow means a push slipped in while full
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        count <= `ROB_DEPTH
    ) else $error("occupancy %0h above depth", count);

    // The slot being allocated is outside the live range, so this also covers it
    a_wb_live: assert property (
        @(posedge clk) disable iff (rst || flush)
        wb_valid |-> wb_live
    ) else $error("writeback tag %0h outside head %0h count %0h",
                  wb_tag, head_idx, count);

endmodule

/* rtl/rob_alloc_if.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

// Allocation channel between dispatch and the reorder buffer
interface rob_alloc_if;

    logic                  valid; // Dispatch offers an entry
    logic                  ready; // Queue not full
    rob_pkg::rob_entry_t   entry;
    logic [`ROB_TAG_W-1:0] tag;   // Tail index the entry lands in

    modport dispatch (
        output valid,
        output entry,
        input  ready,
        input  tag
    );

    modport rob (
        input  valid,
        input  entry,
        output ready,
        output tag
    );

endinterface

/* rtl/rob_pkg.sv */
`include "rob_settings.svh"

package rob_pkg;

    // RV32I major opcodes handled by dispatch
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // Same bits as rd in the R view
        opcode_e    opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef struct packed {
        logic              has_rd;
        logic [4:0]        rd;
        logic              done;
        logic [`XLEN-1:0] value;
    } rob_entry_t;

endpackage

/* rtl/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Reorder buffer sizing

// Queue entries, kept a power of two
`define ROB_DEPTH 8

// Log2 of ROB_DEPTH
`define ROB_TAG_W 3

// Architectural data word
`define XLEN 32

`endif

/* rtl/rob_top.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instr_valid,
    input  logic [`XLEN-1:0]      instr,
    output logic                  instr_ready,
    output logic [`ROB_TAG_W-1:0] instr_tag,
    input  logic                  wb_valid,
    input  logic [`ROB_TAG_W-1:0] wb_tag,
    input  logic [`XLEN-1:0]      wb_result,
    input  logic                  commit_ready,
    output logic                  commit_valid,
    output logic [4:0]            commit_rd,
    output logic [`XLEN-1:0]      commit_value
);

    logic                head_valid;
    rob_pkg::rob_entry_t head_entry;
    logic                pop;

    rob_alloc_if alloc_if ();

    dispatch_unit dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .instr_tag   (instr_tag),
        .alloc       (alloc_if.dispatch)
    );

    reorder_buffer rob_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .alloc      (alloc_if.rob),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_result  (wb_result),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .pop        (pop)
    );

    commit_unit commit_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .head_valid   (head_valid),
        .head_entry   (head_entry),
        .pop          (pop),
        .commit_ready (commit_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

/* testbench/rob_top_tb.sv */
`timescale 1ns/100ps
`include "rob_settings.svh"

module rob_top_tb;

    localparam int TRACE_LINES     = 28;
    localparam int FIELDS          = 7; // Words per trace line
    localparam int WATCHDOG_CYCLES = TRACE_LINES * 40 + 200;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic                  has_rd;
        logic [4:0]            rd;
        logic                  done;
        logic [`XLEN-1:0]      value;
    } model_entry_t;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  instr_valid;
    logic [`XLEN-1:0]      instr;
    logic                  instr_ready;
    logic [`ROB_TAG_W-1:0] instr_tag;
    logic                  wb_valid;
    logic [`ROB_TAG_W-1:0] wb_tag;
    logic [`XLEN-1:0]      wb_result;
    logic                  commit_ready;
    logic                  commit_valid;
    logic [4:0]            commit_rd;
    logic [`XLEN-1:0]      commit_value;

    logic [31:0]           trace_mem [0:TRACE_LINES*FIELDS-1];
    model_entry_t          exp_q [$];      // Dispatched, not yet committed
    logic [`ROB_TAG_W-1:0] next_tag;
    logic                  stalled;        // Commit held by back-pressure last cycle
    int                    errors     = 0;
    int                    checks     = 0;
    int                    commits    = 0;
    int                    dispatched = 0;
    int                    dropped    = 0; // Entries removed by flush

    rob_top rob_top_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .instr_tag    (instr_tag),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_result    (wb_result),
        .commit_ready (commit_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // OP, OP_IMM, LOAD, LUI and JAL write rd
    function automatic logic decode_has_rd(input logic [31:0] word);
        case (word[6:0])
            7'h33, 7'h13, 7'h03, 7'h37, 7'h6f: return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

    function automatic logic stall_draw();
        return ($urandom % 4) == 0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    // A retried line repeats only its dispatch and forces commit_ready high
    task automatic apply_line(input int line, input logic first);
        int base;
        base = line * FIELDS;
        instr_valid  <= trace_mem[base][0];
        instr        <= trace_mem[base + 1];
        wb_valid     <= first && trace_mem[base + 2][0];
        wb_tag       <= trace_mem[base + 3][`ROB_TAG_W-1:0];
        wb_result    <= trace_mem[base + 4];
        commit_ready <= (first ? trace_mem[base + 5][0] : 1'b1) && !stall_draw();
        flush        <= first && trace_mem[base + 6][0];
    endtask

    // Mid-cycle view of the transfers at the next rising edge
    always @(negedge clk) begin
        model_entry_t ent;
        int           idx;
        int           occ;
        if (rst || flush) begin
            if (flush) begin
                dropped += exp_q.size();
            end
            exp_q.delete();
            next_tag = '0;
            stalled  = 1'b0;
        end else begin
            occ = exp_q.size();
            if (commit_valid) begin
                occ = occ - 1; // One entry sits in the output register
            end
            compare_value("instr_ready", instr_ready, occ < `ROB_DEPTH);
            if (stalled) begin
                require_true(commit_valid, "commit_valid dropped while commit_ready was low");
                if (exp_q.size() != 0) begin
                    ent = exp_q[0]; // Oldest outstanding entry is the one held
                    compare_value("commit_rd", commit_rd, ent.rd);
                    compare_value("commit_value", commit_value, ent.value);
                end
            end
            if (commit_valid) begin
                require_true(exp_q.size() != 0, "commit offered with nothing outstanding");
            end
            if (commit_valid && commit_ready && exp_q.size() != 0) begin
                ent = exp_q.pop_front();
                require_true(ent.done, "commit of an instruction that has no result yet");
                compare_value("commit_rd", commit_rd, ent.rd);
                compare_value("commit_value", commit_value, ent.value);
                commits++;
            end
            if (wb_valid) begin
                idx = -1;
                for (int i = exp_q.size() - 1; i >= 0; i--) begin
                    if (exp_q[i].tag == wb_tag) begin
                        idx = i; // Newest holder of the tag is the live one
                        break;
                    end
                end
                require_true(idx >= 0, "writeback to a tag with no outstanding instruction");
                if (idx >= 0) begin
                    ent        = exp_q[idx];
                    ent.value  = wb_result;
                    ent.done   = 1'b1;
                    exp_q[idx] = ent;
                end
            end
            if (instr_valid && instr_ready) begin
                compare_value("instr_tag", instr_tag, next_tag);
                ent.tag    = next_tag;
                ent.has_rd = decode_has_rd(instr);
                ent.rd     = ent.has_rd ? instr[11:7] : 5'd0;
                ent.done   = !ent.has_rd;
                ent.value  = '0;
                exp_q.push_back(ent);
                next_tag = next_tag + 1'b1;
                dispatched++;
            end
            stalled = commit_valid && !commit_ready;
        end
    end

    initial begin
        logic accepted;
        logic first;
        void'($urandom(32'h1a94));
        rst          = 1'b1;
        flush        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        wb_valid     = 1'b0;
        wb_tag       = '0;
        wb_result    = '0;
        commit_ready = 1'b0;
        $readmemh("testbench/rob_trace.txt", trace_mem);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int line = 0; line < TRACE_LINES; line++) begin
            first    = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin // Hold a dispatch until the queue takes it
                @(posedge clk);
                apply_line(line, first);
                first = 1'b0;
                @(negedge clk);
                accepted = !instr_valid || instr_ready;
            end
        end
        @(posedge clk);
        instr_valid  <= 1'b0;
        wb_valid     <= 1'b0;
        flush        <= 1'b0;
        commit_ready <= !stall_draw();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            commit_ready <= !stall_draw();
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d dispatched %0d commits %0d flushed %0d",
                 checks, errors, dispatched, commits, dropped);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Timeout: trace not finished after %0d cycles", WATCHDOG_CYCLES);
        $display("checks %0d errors %0d commits %0d", checks, errors, commits);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* testbench/rob_trace.txt */
// instr_valid instr wb_valid wb_tag wb_result commit_ready flush
// One cycle per line, a dispatch line repeats until the queue accepts it
1 00500093 0 0 00000000 1 0
1 00108133 1 0 00000005 1 0
1 0020a223 1 1 0000000a 1 0
1 0000a183 0 0 00000000 1 0
1 00208463 1 3 cafe0003 1 0
1 123452b7 0 0 00000000 1 0
1 010000ef 1 5 12345000 1 0
1 00700313 0 0 00000000 0 0
1 006283b3 1 7 00000007 0 0
0 00000000 1 0 12345007 0 0
1 00100413 1 6 00000020 1 0
1 0020a223 0 0 00000000 0 0
1 00208463 0 0 00000000 0 0
1 00200493 0 0 00000000 0 0
1 0020a223 0 0 00000000 0 0
1 00812583 0 0 00000000 0 0
1 00208463 0 0 00000000 0 0
1 00300513 0 0 00000000 0 0
1 006283b3 1 1 00000011 1 0
0 00000000 1 6 00000066 1 0
0 00000000 1 0 00000100 1 0
0 00000000 1 4 00000044 1 0
1 123452b7 1 1 00000200 1 0
1 0020a223 0 0 00000000 1 0
0 00000000 0 0 00000000 0 1
1 00500093 0 0 00000000 1 0
1 00108133 1 0 00000abc 1 0
0 00000000 1 1 00000def 1 0
